/* logic/csr_pkg.sv */
package csr_pkg;

    localparam int XLEN        = 32;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = 2;

    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_MHARTID   = 12'hF14;
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSTATUSH  = 12'h310;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_MIP       = 12'h344;

    localparam logic [XLEN-1:0] MISA_RESET    = 32'h4000_0100; // MXL=1, I only.
    localparam logic [XLEN-1:0] MVENDORID_VAL = 32'h0000_05a7;
    localparam logic [XLEN-1:0] MARCHID_VAL   = 32'h0000_0000;
    localparam logic [XLEN-1:0] MIMPID_VAL    = 32'h0000_0000;
    localparam logic [XLEN-1:0] MHARTID_VAL   = 32'h0000_0000;

    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_0088; // MPIE and MIE.
    localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_1800; // MPP reads as M.

    typedef enum logic [1:0] {
        CSRRW = 2'b01,
        CSRRS = 2'b10,
        CSRRC = 2'b11
    } csr_op_e;

    typedef struct packed {
        csr_op_e         op;
        logic [11:0]     addr;
        logic [XLEN-1:0] wdata; // rs1 value.
    } csr_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
        logic            illegal;
    } csr_resp_t;

    typedef struct packed {
        logic            valid;
        logic            mret;
        logic [XLEN-1:0] pc;
        logic [XLEN-2:0] cause; // Exceptions only.
        logic [XLEN-1:0] tval;
    } trap_in_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_fields_t fields;
    } mstatus_u;

    typedef struct packed {
        logic            we;
        logic [11:0]     addr;
        logic [XLEN-1:0] wdata;
    } csr_wr_t;

    // Entry low means MRET, only mstatus is touched then.
    typedef struct packed {
        logic            en;
        logic            entry;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
        mstatus_u        mstatus;
    } csr_cap_t;

endpackage

/* logic/csr_req_queue.sv */
module csr_req_queue (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              push_i,
    input  csr_pkg::csr_req_t req_i,
    input  logic              pop_i,
    output csr_pkg::csr_req_t head_o,
    output logic              empty_o,
    output logic              credit_o
);
    csr_pkg::csr_req_t                mem [csr_pkg::QUEUE_DEPTH];
    logic [csr_pkg::QUEUE_AW-1:0]     wr_ptr_q;
    logic [csr_pkg::QUEUE_AW-1:0]     rd_ptr_q;
    logic [csr_pkg::QUEUE_AW:0]       count_q;
    logic                             full;
    logic                             pop_ok;

    assign empty_o  = (count_q == '0);
    assign full     = (int'(count_q) == csr_pkg::QUEUE_DEPTH);
    assign pop_ok   = pop_i & ~empty_o;
    assign credit_o = pop_ok; // One credit back per removed entry.
    assign head_o   = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (~reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // Depth is a power of two.
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q
                     + (csr_pkg::QUEUE_AW + 1)'(push_i)
                     - (csr_pkg::QUEUE_AW + 1)'(pop_ok);
        end
    end

    // Sender credits and exec pop rule keep the FIFO in range.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (~reset_n)
        !(push_i && full) && !(pop_i && empty_o)
    );

endmodule

/* logic/csr_exec.sv */
module csr_exec (
    input  logic                     clk,
    input  logic                     reset_n,
    input  csr_pkg::csr_req_t        head_i,
    input  logic                     empty_i,
    input  logic                     stall_i,
    output logic                     pop_o,
    output logic [11:0]              rd_addr_o,
    input  logic [csr_pkg::XLEN-1:0] rdata_i,
    input  logic                     illegal_i,
    output csr_pkg::csr_wr_t         wr_o,
    output csr_pkg::csr_resp_t       resp_o
);
    logic [csr_pkg::XLEN-1:0] new_val;
    logic                     src_nz;
    logic                     do_write;
    logic                     resp_valid_q;
    logic [csr_pkg::XLEN-1:0] resp_rdata_q;
    logic                     resp_illegal_q;

    assign pop_o     = ~empty_i & ~stall_i;
    assign rd_addr_o = head_i.addr;
    assign src_nz    = |head_i.wdata;

    always_comb begin
        case (head_i.op)
            csr_pkg::CSRRW: new_val = head_i.wdata;
            csr_pkg::CSRRS: new_val = rdata_i | head_i.wdata;
            csr_pkg::CSRRC: new_val = rdata_i & ~head_i.wdata;
            default:        new_val = rdata_i;
        endcase
    end

    // RS and RC with a zero source only read.
    assign do_write = pop_o & ((head_i.op == csr_pkg::CSRRW) | src_nz);

    assign wr_o = '{we: do_write, addr: head_i.addr, wdata: new_val};

    always_ff @(posedge clk, negedge reset_n) begin
        if (~reset_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            resp_rdata_q   <= rdata_i; // Old value.
            resp_illegal_q <= illegal_i;
        end
    end

    assign resp_o = '{valid: resp_valid_q, rdata: resp_rdata_q, illegal: resp_illegal_q};

    a_no_pop_in_trap: assert property (
        @(posedge clk) disable iff (~reset_n)
        stall_i |-> !pop_o
    );

endmodule

/* logic/csr_file.sv */
module csr_file (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic [11:0]              rd_addr_i,
    output logic [csr_pkg::XLEN-1:0] rdata_o,
    output logic                     illegal_o,
    input  csr_pkg::csr_wr_t         wr_i,
    input  csr_pkg::csr_cap_t        cap_i,
    output csr_pkg::mstatus_u        mstatus_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic [csr_pkg::XLEN-1:0] mtvec_o
);
    csr_pkg::mstatus_u        mstatus_q;
    logic [csr_pkg::XLEN-1:0] misa_q;
    logic [csr_pkg::XLEN-1:0] mie_q;
    logic [csr_pkg::XLEN-1:0] mtvec_q;
    logic [csr_pkg::XLEN-1:0] mstatush_q;
    logic [csr_pkg::XLEN-1:0] mepc_q;
    logic [csr_pkg::XLEN-1:0] mcause_q;
    logic [csr_pkg::XLEN-1:0] mtval_q;
    logic [csr_pkg::XLEN-1:0] mip_q;
    logic [csr_pkg::XLEN-1:0] mscratch_q;
    logic                     known;
    logic                     id_wr;
    logic                     wr_en;

    always_comb begin
        known = 1'b1;
        case (rd_addr_i)
            csr_pkg::CSR_MVENDORID: rdata_o = csr_pkg::MVENDORID_VAL;
            csr_pkg::CSR_MARCHID:   rdata_o = csr_pkg::MARCHID_VAL;
            csr_pkg::CSR_MIMPID:    rdata_o = csr_pkg::MIMPID_VAL;
            csr_pkg::CSR_MHARTID:   rdata_o = csr_pkg::MHARTID_VAL;
            csr_pkg::CSR_MSTATUS:   rdata_o = mstatus_q.raw;
            csr_pkg::CSR_MISA:      rdata_o = misa_q;
            csr_pkg::CSR_MIE:       rdata_o = mie_q;
            csr_pkg::CSR_MTVEC:     rdata_o = mtvec_q;
            csr_pkg::CSR_MSTATUSH:  rdata_o = mstatush_q;
            csr_pkg::CSR_MEPC:      rdata_o = mepc_q;
            csr_pkg::CSR_MCAUSE:    rdata_o = mcause_q;
            csr_pkg::CSR_MTVAL:     rdata_o = mtval_q;
            csr_pkg::CSR_MIP:       rdata_o = mip_q;
            csr_pkg::CSR_MSCRATCH:  rdata_o = mscratch_q;
            default: begin
                rdata_o = '0;
                known   = 1'b0;
            end
        endcase
    end

    assign id_wr = wr_i.we & (wr_i.addr inside {csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID,
                                                csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID});
    assign illegal_o = ~known | id_wr;
    assign wr_en     = wr_i.we & ~illegal_o; // Illegal access leaves state alone.

    always_ff @(posedge clk, negedge reset_n) begin
        if (~reset_n) begin
            mstatus_q.raw <= csr_pkg::MSTATUS_RESET;
            misa_q        <= csr_pkg::MISA_RESET;
            mie_q         <= '0;
            mtvec_q       <= '0;
            mstatush_q    <= '0;
            mepc_q        <= '0;
            mcause_q      <= '0;
            mtval_q       <= '0;
            mip_q         <= '0;
            mscratch_q    <= '0;
        end else if (cap_i.en) begin
            mstatus_q <= cap_i.mstatus;
            if (cap_i.entry) begin
                mepc_q   <= cap_i.mepc;
                mcause_q <= cap_i.mcause;
                mtval_q  <= cap_i.mtval;
            end
        end else if (wr_en) begin
            case (wr_i.addr)
                csr_pkg::CSR_MSTATUS: begin
                    mstatus_q.raw <= (mstatus_q.raw & ~csr_pkg::MSTATUS_WMASK)
                                   | (wr_i.wdata & csr_pkg::MSTATUS_WMASK);
                end
                csr_pkg::CSR_MISA:     misa_q     <= wr_i.wdata;
                csr_pkg::CSR_MIE:      mie_q      <= wr_i.wdata;
                csr_pkg::CSR_MTVEC:    mtvec_q    <= wr_i.wdata;
                csr_pkg::CSR_MSTATUSH: mstatush_q <= wr_i.wdata;
                csr_pkg::CSR_MEPC:     mepc_q     <= wr_i.wdata;
                csr_pkg::CSR_MCAUSE:   mcause_q   <= wr_i.wdata;
                csr_pkg::CSR_MTVAL:    mtval_q    <= wr_i.wdata;
                csr_pkg::CSR_MIP:      mip_q      <= wr_i.wdata;
                csr_pkg::CSR_MSCRATCH: mscratch_q <= wr_i.wdata;
                default: ;
            endcase
        end
    end

    assign mstatus_o = mstatus_q;
    assign mepc_o    = mepc_q;
    assign mtvec_o   = mtvec_q;

    // Exec holds off while trap control owns the file.
    a_wr_cap_excl: assert property (
        @(posedge clk) disable iff (~reset_n)
        !(wr_i.we && cap_i.en)
    );

endmodule

/* logic/trap_ctrl.sv */
module trap_ctrl (
    input  logic                     clk,
    input  logic                     reset_n,
    input  csr_pkg::trap_in_t        trap_i,
    input  csr_pkg::mstatus_u        mstatus_i,
    input  logic [csr_pkg::XLEN-1:0] mepc_i,
    input  logic [csr_pkg::XLEN-1:0] mtvec_i,
    output csr_pkg::csr_cap_t        cap_o,
    output logic                     stall_o,
    output csr_pkg::redirect_t       redirect_o
);
    csr_pkg::mstatus_u        mstatus_nxt;
    logic                     redir_valid_q;
    logic [csr_pkg::XLEN-1:0] redir_pc_q;

    always_comb begin
        mstatus_nxt = mstatus_i;
        if (trap_i.mret) begin
            mstatus_nxt.fields.mie  = mstatus_i.fields.mpie;
            mstatus_nxt.fields.mpie = 1'b1;
        end else begin
            mstatus_nxt.fields.mpie = mstatus_i.fields.mie;
            mstatus_nxt.fields.mie  = 1'b0;
        end
    end

    always_comb begin
        cap_o.en      = trap_i.valid;
        cap_o.entry   = ~trap_i.mret;
        cap_o.mepc    = {trap_i.pc[csr_pkg::XLEN-1:2], 2'b00};
        cap_o.mcause  = {1'b0, trap_i.cause}; // Interrupt bit always clear.
        cap_o.mtval   = trap_i.tval;
        cap_o.mstatus = mstatus_nxt;
    end

    assign stall_o = trap_i.valid;

    always_ff @(posedge clk, negedge reset_n) begin
        if (~reset_n) begin
            redir_valid_q <= 1'b0;
        end else begin
            redir_valid_q <= trap_i.valid;
        end
    end

    // Direct mode only, mode bits dropped.
    always_ff @(posedge clk) begin
        if (trap_i.valid) begin
            redir_pc_q <= trap_i.mret ? mepc_i : {mtvec_i[csr_pkg::XLEN-1:2], 2'b00};
        end
    end

    assign redirect_o = '{valid: redir_valid_q, pc: redir_pc_q};

endmodule

/* logic/csr_unit_top.sv */
module csr_unit_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               req_valid_i,
    input  csr_pkg::csr_req_t  req_i,
    output logic               credit_o,
    output csr_pkg::csr_resp_t resp_o,
    input  csr_pkg::trap_in_t  trap_i,
    output csr_pkg::redirect_t redirect_o
);
    csr_pkg::csr_req_t        head;
    logic                     empty;
    logic                     pop;
    logic                     stall;
    logic [11:0]              rd_addr;
    logic [csr_pkg::XLEN-1:0] rdata;
    logic                     illegal;
    csr_pkg::csr_wr_t         wr;
    csr_pkg::csr_cap_t        cap;
    csr_pkg::mstatus_u        mstatus;
    logic [csr_pkg::XLEN-1:0] mepc;
    logic [csr_pkg::XLEN-1:0] mtvec;

    csr_req_queue csr_req_queue_i (
        .clk, .reset_n, .push_i(req_valid_i), .req_i, .pop_i(pop),
        .head_o(head), .empty_o(empty), .credit_o
    );

    csr_exec csr_exec_i (
        .clk, .reset_n, .head_i(head), .empty_i(empty), .stall_i(stall), .pop_o(pop),
        .rd_addr_o(rd_addr), .rdata_i(rdata), .illegal_i(illegal), .wr_o(wr), .resp_o
    );

    csr_file csr_file_i (
        .clk, .reset_n, .rd_addr_i(rd_addr), .rdata_o(rdata), .illegal_o(illegal),
        .wr_i(wr), .cap_i(cap), .mstatus_o(mstatus), .mepc_o(mepc), .mtvec_o(mtvec)
    );

    trap_ctrl trap_ctrl_i (
        .clk, .reset_n, .trap_i, .mstatus_i(mstatus), .mepc_i(mepc), .mtvec_i(mtvec),
        .cap_o(cap), .stall_o(stall), .redirect_o
    );

endmodule

/* sim/csr_unit_checker.sv */
module csr_unit_checker (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               req_valid_i,
    input  csr_pkg::csr_req_t  req_i,
    input  logic               credit_i,
    input  csr_pkg::csr_resp_t resp_i,
    input  csr_pkg::trap_in_t  trap_i,
    input  csr_pkg::redirect_t redirect_i,
    input  logic               test_end_i,
    input  int                 test_num_i,
    output int                 errors_o,
    output int                 tests_run_o,
    output int                 tests_failed_o
);
    logic [31:0]       regs [logic [11:0]];
    csr_pkg::csr_req_t pend_q [$];
    int                credits;
    int                errors = 0;
    int                errs_seen = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    logic              exp_resp;
    logic              exp_known;
    logic              exp_ill;
    logic              exp_redir;
    logic [31:0]       exp_rdata;
    logic [31:0]       exp_pc;

    assign errors_o       = errors;
    assign tests_run_o    = tests_run;
    assign tests_failed_o = tests_failed;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string what);
        $display("%s", what);
        errors++;
    endtask

    function automatic string test_name(input int n);
        case (n)
            1: return "reset_values";
            2: return "random_rmw";
            3: return "illegal_access";
            4: return "trap_entry";
            5: return "mret";
            default: return "mixed_credits";
        endcase
    endfunction

    task automatic reset_model();
        regs.delete();
        regs[csr_pkg::CSR_MSTATUS]  = 32'h0000_1800; // MPP reads as M.
        regs[csr_pkg::CSR_MISA]     = csr_pkg::MISA_RESET;
        regs[csr_pkg::CSR_MIE]      = '0;
        regs[csr_pkg::CSR_MTVEC]    = '0;
        regs[csr_pkg::CSR_MSTATUSH] = '0;
        regs[csr_pkg::CSR_MEPC]     = '0;
        regs[csr_pkg::CSR_MCAUSE]   = '0;
        regs[csr_pkg::CSR_MTVAL]    = '0;
        regs[csr_pkg::CSR_MIP]      = '0;
        regs[csr_pkg::CSR_MSCRATCH] = '0;
        pend_q.delete();
        credits   = csr_pkg::QUEUE_DEPTH;
        exp_resp  = 1'b0;
        exp_redir = 1'b0;
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] a, output logic known,
                                               output logic is_id);
        known = 1'b1;
        is_id = 1'b1;
        case (a)
            csr_pkg::CSR_MVENDORID: return csr_pkg::MVENDORID_VAL;
            csr_pkg::CSR_MARCHID:   return csr_pkg::MARCHID_VAL;
            csr_pkg::CSR_MIMPID:    return csr_pkg::MIMPID_VAL;
            csr_pkg::CSR_MHARTID:   return csr_pkg::MHARTID_VAL;
            default: ;
        endcase
        is_id = 1'b0;
        known = (regs.exists(a) != 0);
        return known ? regs[a] : '0;
    endfunction

    task automatic apply_req(input csr_pkg::csr_req_t r);
        logic [31:0] old;
        logic [31:0] nv;
        logic        is_id;
        logic        we;
        old       = model_read(r.addr, exp_known, is_id);
        we        = (r.op == csr_pkg::CSRRW) || (r.wdata != '0); // Zero source only reads.
        exp_resp  = 1'b1;
        exp_rdata = old;
        exp_ill   = !exp_known || (is_id && we);
        if (exp_ill || !we) begin
            return;
        end
        case (r.op)
            csr_pkg::CSRRW: nv = r.wdata;
            csr_pkg::CSRRS: nv = old | r.wdata;
            default:        nv = old & ~r.wdata;
        endcase
        if (r.addr == csr_pkg::CSR_MSTATUS) begin
            nv = (old & ~csr_pkg::MSTATUS_WMASK) | (nv & csr_pkg::MSTATUS_WMASK);
        end
        regs[r.addr] = nv;
    endtask

    task automatic apply_trap(input csr_pkg::trap_in_t t);
        logic [31:0] ms;
        logic [31:0] tvec;
        ms        = regs[csr_pkg::CSR_MSTATUS];
        tvec      = regs[csr_pkg::CSR_MTVEC];
        exp_redir = 1'b1;
        if (t.mret) begin
            exp_pc = regs[csr_pkg::CSR_MEPC];
            ms[3]  = ms[7]; // MIE from MPIE.
            ms[7]  = 1'b1;
        end else begin
            exp_pc = {tvec[31:2], 2'b00};
            regs[csr_pkg::CSR_MEPC]   = {t.pc[31:2], 2'b00};
            regs[csr_pkg::CSR_MCAUSE] = {1'b0, t.cause};
            regs[csr_pkg::CSR_MTVAL]  = t.tval;
            ms[7]  = ms[3];
            ms[3]  = 1'b0;
        end
        regs[csr_pkg::CSR_MSTATUS] = ms;
    endtask

    task automatic finish_test();
        if (pend_q.size() != 0 || credits != csr_pkg::QUEUE_DEPTH) begin
            report("credit pulses do not match the requests sent");
        end
        tests_run++;
        if (errors == errs_seen) begin
            $display("check %0d %s: ok", test_num_i, test_name(test_num_i));
        end else begin
            tests_failed++;
            $display("check %0d %s: %0d errors", test_num_i, test_name(test_num_i),
                     errors - errs_seen);
        end
        errs_seen = errors;
    endtask

    always @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            reset_model();
        end else begin
            check_value("resp_o.valid", 32'(resp_i.valid), 32'(exp_resp));
            if (exp_resp && resp_i.valid) begin
                if (exp_known) begin
                    check_value("resp_o.rdata", resp_i.rdata, exp_rdata);
                end
                check_value("resp_o.illegal", 32'(resp_i.illegal), 32'(exp_ill));
            end
            check_value("redirect_o.valid", 32'(redirect_i.valid), 32'(exp_redir));
            if (exp_redir && redirect_i.valid) begin
                check_value("redirect_o.pc", redirect_i.pc, exp_pc);
            end
            exp_resp  = 1'b0;
            exp_redir = 1'b0;
            credits   = credits + int'(credit_i) - int'(req_valid_i);
            if (credits < 0) begin
                report("pipeline credit count went negative");
            end
            if (credit_i) begin
                if (pend_q.size() == 0) begin
                    report("credit pulse with no request outstanding");
                end else begin
                    apply_req(pend_q.pop_front());
                end
            end
            if (req_valid_i) begin
                pend_q.push_back(req_i);
            end
            if (trap_i.valid) begin
                apply_trap(trap_i);
            end
            if (test_end_i) begin
                finish_test();
            end
        end
    end

endmodule

/* sim/csr_unit_tb.sv */
module csr_unit_tb;
    logic               clk;
    logic               reset_n;
    logic               req_valid_i;
    csr_pkg::csr_req_t  req_i;
    logic               credit_o;
    csr_pkg::csr_resp_t resp_o;
    csr_pkg::trap_in_t  trap_i;
    csr_pkg::redirect_t redirect_o;
    logic               test_end;
    int                 test_num;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    int                 credits;
    int                 wait_limit = 200;
    logic               timed_out;

    csr_unit_top csr_unit_top_i (
        .clk, .reset_n, .req_valid_i, .req_i, .credit_o, .resp_o, .trap_i, .redirect_o
    );

    csr_unit_checker checker_i (
        .clk, .reset_n, .req_valid_i, .req_i, .credit_i(credit_o), .resp_i(resp_o), .trap_i,
        .redirect_i(redirect_o), .test_end_i(test_end), .test_num_i(test_num),
        .errors_o(errors), .tests_run_o(tests_run), .tests_failed_o(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 0 to 9 are storage, 10 to 13 the ID registers.
    function automatic logic [11:0] csr_addr(input int n);
        case (n)
            0:  return csr_pkg::CSR_MSTATUS;
            1:  return csr_pkg::CSR_MISA;
            2:  return csr_pkg::CSR_MIE;
            3:  return csr_pkg::CSR_MTVEC;
            4:  return csr_pkg::CSR_MSTATUSH;
            5:  return csr_pkg::CSR_MEPC;
            6:  return csr_pkg::CSR_MCAUSE;
            7:  return csr_pkg::CSR_MTVAL;
            8:  return csr_pkg::CSR_MIP;
            9:  return csr_pkg::CSR_MSCRATCH;
            10: return csr_pkg::CSR_MVENDORID;
            11: return csr_pkg::CSR_MARCHID;
            12: return csr_pkg::CSR_MIMPID;
            default: return csr_pkg::CSR_MHARTID;
        endcase
    endfunction

    function automatic logic [31:0] data_word();
        return ($urandom % 4 == 0) ? 32'h0 : $urandom; // Zero often enough for RS/RC.
    endfunction

    function automatic csr_pkg::csr_op_e random_op();
        return csr_pkg::csr_op_e'(2'($urandom % 3 + 1));
    endfunction

    task automatic tick();
        @(posedge clk);
        if (credit_o) begin
            credits++;
        end
        req_valid_i <= 1'b0;
        trap_i      <= '0;
        test_end    <= 1'b0;
    endtask

    task automatic send_req(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] data);
        int waited = 0;
        if (timed_out) begin
            return;
        end
        tick();
        while (credits == 0) begin
            if (waited == wait_limit) begin
                $display("timeout: no request credit came back in %0d cycles", wait_limit);
                timed_out = 1'b1;
                return;
            end
            tick();
            waited++;
        end
        req_valid_i <= 1'b1;
        req_i       <= '{op: op, addr: addr, wdata: data};
        credits--;
    endtask

    task automatic read_csr(input logic [11:0] addr);
        send_req(csr_pkg::CSRRS, addr, '0);
    endtask

    task automatic read_all();
        for (int i = 0; i < 14; i++) begin
            read_csr(csr_addr(i));
        end
    endtask

    task automatic send_trap(input logic mret, input logic [31:0] pc, input logic [30:0] cause,
                             input logic [31:0] tval);
        tick();
        trap_i <= '{valid: 1'b1, mret: mret, pc: pc, cause: cause, tval: tval};
    endtask

    task automatic drain();
        int waited = 0;
        if (timed_out) begin
            return;
        end
        tick();
        while (credits != csr_pkg::QUEUE_DEPTH) begin
            if (waited == wait_limit) begin
                $display("timeout: outstanding requests not popped in %0d cycles", wait_limit);
                timed_out = 1'b1;
                return;
            end
            tick();
            waited++;
        end
        tick(); // Last response and redirect land here.
        tick();
    endtask

    task automatic end_test(input int n);
        drain();
        if (timed_out) begin
            return;
        end
        test_num <= n;
        test_end <= 1'b1;
        tick();
        tick(); // Counts settle after the closing edge.
    endtask

    task automatic run_tests();
        int sel;
        read_all();
        end_test(1);
        repeat (200) send_req(random_op(), csr_addr(int'($urandom % 10)), data_word());
        read_all();
        end_test(2);
        repeat (60) begin
            if ($urandom % 2 == 0) begin
                send_req(random_op(), csr_addr(10 + int'($urandom % 4)), data_word());
            end else begin
                send_req(random_op(), 12'h7c0 + 12'($urandom % 16), data_word());
            end
        end
        read_all();
        end_test(3);
        repeat (20) begin
            send_req(csr_pkg::CSRRW, csr_pkg::CSR_MTVEC, $urandom);
            send_req(csr_pkg::CSRRW, csr_pkg::CSR_MSTATUS, $urandom);
            send_trap(1'b0, $urandom, 31'($urandom), $urandom);
            read_csr(csr_pkg::CSR_MEPC);
            read_csr(csr_pkg::CSR_MCAUSE);
            read_csr(csr_pkg::CSR_MTVAL);
            read_csr(csr_pkg::CSR_MSTATUS);
        end
        end_test(4);
        repeat (20) begin
            send_req(csr_pkg::CSRRW, csr_pkg::CSR_MSTATUS, $urandom);
            send_req(csr_pkg::CSRRW, csr_pkg::CSR_MEPC, $urandom);
            send_trap(1'b1, '0, '0, '0);
            read_csr(csr_pkg::CSR_MSTATUS);
        end
        end_test(5);
        repeat (300) begin
            sel = int'($urandom % 8);
            if (sel == 0) begin
                send_trap(1'($urandom), $urandom, 31'($urandom), $urandom);
            end else if (sel == 1) begin
                tick(); // Idle cycle lets the queue drain.
            end else begin
                send_req(random_op(), csr_addr(int'($urandom % 14)), data_word());
            end
        end
        read_all();
        end_test(6);
    endtask

    initial begin
        void'($urandom(32'h6226_428c));
        reset_n     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        trap_i      = '0;
        test_end    = 1'b0;
        test_num    = 0;
        credits     = csr_pkg::QUEUE_DEPTH;
        timed_out   = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        run_tests();
        $display("%0d checks run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (timed_out || errors != 0 || tests_failed != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

/* build.f */
logic/csr_pkg.sv
logic/csr_req_queue.sv
logic/csr_exec.sv
logic/csr_file.sv
logic/trap_ctrl.sv
logic/csr_unit_top.sv
sim/csr_unit_checker.sv
sim/csr_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = csr_unit_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
